// ==== design/rename_settings.svh ====
//**************************************************************************
// Rename subsystem sizes, shared by the package, the RTL and the testbench.
//**************************************************************************

`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// number of architectural registers, register 0 is hardwired to zero.
`define RN_REGS 32

// copies kept per register. Must be a power of two so pointers wrap for free.
`define RN_DEPTH 4

// width of one register value.
`define RN_WIDTH 64

`endif

// ==== design/renamePkg.sv ====
//**************************************************************************
// Rename package with index, pointer and data types and the opcodes.
//**************************************************************************

`include "rename_settings.svh"

package renamePkg;

	// architectural register number.
	typedef logic [$clog2(`RN_REGS)-1:0] regIdx_t;

	// copy number inside one register, also wide enough for an outstanding count.
	typedef logic [$clog2(`RN_DEPTH)-1:0] renamePtr_t;

	typedef logic [`RN_WIDTH-1:0] regData_t;

	// one operation per cycle from the issue side.
	typedef enum logic [1:0] {
		OP_NONE   = 2'd0, // idle cycle.
		OP_WRITE  = 2'd1, // speculative write into the next free copy.
		OP_COMMIT = 2'd2, // oldest outstanding copy becomes architectural.
		OP_FLUSH  = 2'd3  // drop every outstanding copy.
	} renameOp_e;

endpackage

// ==== design/rfWriteIf.sv ====
//**************************************************************************
// Single write port into the rename register file.
//**************************************************************************

`timescale 1ns/1ps

interface rfWriteIf
	import renamePkg::*;
();

	regIdx_t    index;  // architectural register.
	renamePtr_t rename; // copy inside that register.
	logic       wen;    // one-cycle pulse per write.
	regData_t   data;

	// the allocator drives the write.
	modport alloc (
		output index, rename, wen, data
	);

	// the register file stores it at the clock edge.
	modport file (
		input index, rename, wen, data
	);

endinterface

// ==== design/renameAlloc.sv ====
//**************************************************************************
// Rename allocator. Decodes operations, tracks speculative pointers and
// outstanding counts, and issues register file writes and commit strobes.
//**************************************************************************

`timescale 1ns/1ps

`include "rename_settings.svh"

module renameAlloc
	import renamePkg::*;
(
	input  logic      CLK,
	input  logic      arstN,

	input  renameOp_e opKind,
	input  regIdx_t   opIndex,
	input  regData_t  opData,
	output logic      full,

	rfWriteIf.alloc   wr,

	output logic      commitStrobe,
	output regIdx_t   commitIndex
);

	// newest copy written for each register.
	renamePtr_t specPtr [`RN_REGS];

	// number of copies written but not yet committed.
	renamePtr_t outCount [`RN_REGS];

	logic isZero;
	logic doWrite;
	logic doCommit;

	assign isZero = (opIndex == '0);

	// one copy always stays reserved for the committed value.
	assign full = !isZero && (outCount[opIndex] == renamePtr_t'(`RN_DEPTH - 1));

	assign doWrite  = (opKind == OP_WRITE) && !isZero && !full;
	assign doCommit = (opKind == OP_COMMIT) && !isZero && (outCount[opIndex] != '0);

	// the write lands in the copy right after the newest one.
	assign wr.index  = opIndex;
	assign wr.rename = renamePtr_t'(specPtr[opIndex] + 1'b1);
	assign wr.wen    = doWrite;
	assign wr.data   = opData;

	assign commitStrobe = doCommit; // only legal commits reach the tracker.
	assign commitIndex  = opIndex;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `RN_REGS; i++) begin
				specPtr[i]  <= '0;
				outCount[i] <= '0;
			end
		end else if (opKind == OP_FLUSH) begin
			// walking back by the count lands each pointer on its committed copy.
			for (int i = 0; i < `RN_REGS; i++) begin
				specPtr[i]  <= renamePtr_t'(specPtr[i] - outCount[i]);
				outCount[i] <= '0;
			end
		end else if (doWrite) begin
			specPtr[opIndex]  <= renamePtr_t'(specPtr[opIndex] + 1'b1);
			outCount[opIndex] <= renamePtr_t'(outCount[opIndex] + 1'b1);
		end else if (doCommit) begin
			// the committed pointer itself lives in the tracker.
			outCount[opIndex] <= renamePtr_t'(outCount[opIndex] - 1'b1);
		end
	end

endmodule

// ==== design/regFile.sv ====
//**************************************************************************
// Physical register file holding every rename copy of every register.
// One write port and one combinational read port.
//**************************************************************************

`timescale 1ns/1ps

`include "rename_settings.svh"

module regFile
	import renamePkg::*;
(
	input  logic       CLK,
	input  logic       arstN,

	rfWriteIf.file     wr,

	input  regIdx_t    readIndex,
	input  renamePtr_t readRename,
	output regData_t   readValue
);

	// register 0 has no storage at all.
	regData_t copies [1:`RN_REGS-1][`RN_DEPTH];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int r = 1; r < `RN_REGS; r++) begin
				for (int d = 0; d < `RN_DEPTH; d++) begin
					copies[r][d] <= '0;
				end
			end
		end else if (wr.wen && (wr.index != '0)) begin
			copies[wr.index][wr.rename] <= wr.data;
		end
	end

	// reads of register 0 return zero whatever copy is asked for.
	always_comb begin
		if (readIndex == '0) begin
			readValue = '0;
		end else begin
			readValue = copies[readIndex][readRename];
		end
	end

endmodule

// ==== design/commitTracker.sv ====
//**************************************************************************
// Commit tracker. Keeps the committed copy of each register and serves
// architectural reads with one cycle of latency.
//**************************************************************************

`timescale 1ns/1ps

`include "rename_settings.svh"

module commitTracker
	import renamePkg::*;
(
	input  logic       CLK,
	input  logic       arstN,

	input  logic       commitStrobe,
	input  regIdx_t    commitIndex,

	input  logic       archReadValid,
	input  regIdx_t    archReadIndex,

	output regIdx_t    readIndex,
	output renamePtr_t readRename,
	input  regData_t   readValue,

	output logic       archReadDataValid,
	output regData_t   archReadData
);

	// copy that currently holds the architectural value.
	renamePtr_t commitPtr [`RN_REGS];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `RN_REGS; i++) begin
				commitPtr[i] <= '0;
			end
		end else if (commitStrobe) begin
			commitPtr[commitIndex] <= renamePtr_t'(commitPtr[commitIndex] + 1'b1);
		end
	end

	// the pointer is sampled before the edge, so a commit in the same cycle is not seen.
	assign readIndex  = archReadIndex;
	assign readRename = commitPtr[archReadIndex];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			archReadDataValid <= 1'b0;
			archReadData      <= '0;
		end else begin
			archReadDataValid <= archReadValid; // one pulse per request.
			if (archReadValid) begin
				archReadData <= readValue; // holds until the next request.
			end
		end
	end

endmodule

// ==== design/renameCore.sv ====
//**************************************************************************
// Register rename top level with allocator, register file and commit tracker.
//**************************************************************************

`timescale 1ns/1ps

module renameCore
	import renamePkg::*;
(
	input  logic      CLK,
	input  logic      arstN,

	input  renameOp_e opKind,
	input  regIdx_t   opIndex,
	input  regData_t  opData,
	output logic      full,

	input  logic      archReadValid,
	input  regIdx_t   archReadIndex,
	output logic      archReadDataValid,
	output regData_t  archReadData
);

	rfWriteIf wrBus();

	logic       commitStrobe;
	regIdx_t    commitIndex;
	regIdx_t    readIndex;
	renamePtr_t readRename;
	regData_t   readValue;

	renameAlloc i_alloc (
		.CLK          (CLK),
		.arstN        (arstN),
		.opKind       (opKind),
		.opIndex      (opIndex),
		.opData       (opData),
		.full         (full),
		.wr           (wrBus.alloc),
		.commitStrobe (commitStrobe),
		.commitIndex  (commitIndex)
	);

	regFile i_regFile (
		.CLK        (CLK),
		.arstN      (arstN),
		.wr         (wrBus.file),
		.readIndex  (readIndex),
		.readRename (readRename),
		.readValue  (readValue)
	);

	commitTracker i_tracker (
		.CLK               (CLK),
		.arstN             (arstN),
		.commitStrobe      (commitStrobe),
		.commitIndex       (commitIndex),
		.archReadValid     (archReadValid),
		.archReadIndex     (archReadIndex),
		.readIndex         (readIndex),
		.readRename        (readRename),
		.readValue         (readValue),
		.archReadDataValid (archReadDataValid),
		.archReadData      (archReadData)
	);

endmodule

// ==== verif/clkGen.sv ====
//**************************************************************************
// Testbench clock and reset. 20 ns clock, reset held for 5 cycles.
//**************************************************************************

`timescale 1ns/1ps

module clkGen (
	output logic CLK,
	output logic arstN
);

	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	initial begin
		arstN = 1'b0;
		repeat (5) @(posedge CLK);
		#1 arstN = 1'b1; // released just after the fifth edge.
	end

endmodule

// ==== verif/renameCore_checker.sv ====
//**************************************************************************
// Protocol assertions on the architectural read port of the rename core.
//**************************************************************************

`timescale 1ns/1ps

module renameCore_checker
	import renamePkg::*;
(
	input logic     CLK,
	input logic     arstN,
	input logic     archReadValid,
	input regIdx_t  archReadIndex,
	input logic     archReadDataValid,
	input regData_t archReadData
);

	// one result per request, exactly one cycle later.
	validFollowsRead: assert property (@(posedge CLK) disable iff (!arstN)
		archReadDataValid == $past(archReadValid))
	else $error("read data valid does not follow the read request by one cycle");

	zeroRegReadsZero: assert property (@(posedge CLK) disable iff (!arstN)
		(archReadValid && (archReadIndex == '0)) |=> (archReadData == '0))
	else $error("read of register zero returned a nonzero value");

	// the valid flop is cleared asynchronously, so no pulse can appear in reset.
	quietInReset: assert property (@(posedge CLK) !arstN |-> !archReadDataValid)
	else $error("read data valid is high while in reset");

endmodule

bind renameCore renameCore_checker i_checker (.*);

// ==== verif/tb_renameCore.sv ====
//**************************************************************************
// Testbench for the register rename core, checked against a queue model.
//**************************************************************************

`timescale 1ns/1ps

`include "rename_settings.svh"

module tb_renameCore
	import renamePkg::*;
();

	logic      CLK;
	logic      arstN;
	renameOp_e opKind;
	regIdx_t   opIndex;
	regData_t  opData;
	logic      full;
	logic      archReadValid;
	regIdx_t   archReadIndex;
	logic      archReadDataValid;
	regData_t  archReadData;

	// model state. Outstanding copies are kept oldest first.
	regData_t committed [`RN_REGS];
	regData_t pending [`RN_REGS][$];

	regData_t expData [$]; // expected read results in request order.
	regIdx_t  expIdx [$];

	integer    seed;
	int        checks;
	int        testErrors;
	int        totalErrors;
	int        testsRun;
	int        testsFailed;
	int        waited;
	int        pick;
	logic      timedOut;
	renameOp_e kind;
	regData_t  gotExp;
	regIdx_t   gotIdx;

	clkGen i_clk (.CLK(CLK), .arstN(arstN));

	renameCore i_dut (.*);

	// applies one operation to the model and returns the full level seen before it.
	function automatic logic applyOp(input renameOp_e op, input regIdx_t idx,
			input regData_t data);
		logic isFull;
		isFull = (idx != '0) && (pending[idx].size() == `RN_DEPTH - 1);
		case (op)
			OP_WRITE: begin
				if ((idx != '0) && !isFull) begin
					pending[idx].push_back(data);
				end
			end
			OP_COMMIT: begin
				if ((idx != '0) && (pending[idx].size() != 0)) begin
					committed[idx] = pending[idx].pop_front();
				end
			end
			OP_FLUSH: begin
				for (int r = 0; r < `RN_REGS; r++) pending[r].delete();
			end
			default: ;
		endcase
		return isFull;
	endfunction

	function automatic regData_t committedValue(input regIdx_t idx);
		return (idx == '0) ? regData_t'(0) : committed[idx];
	endfunction

	// one clock of stimulus. The read sees the model before this operation.
	task automatic runCycle(input renameOp_e op, input regIdx_t idx, input regData_t data,
			input logic rdEn, input regIdx_t rdIdx);
		logic expFull;
		@(posedge CLK);
		#1;
		opKind        = op;
		opIndex       = idx;
		opData        = data;
		archReadValid = rdEn;
		archReadIndex = rdIdx;
		if (rdEn) begin
			expData.push_back(committedValue(rdIdx));
			expIdx.push_back(rdIdx);
		end
		expFull = applyOp(op, idx, data);
		#5;
		checks++;
		assert (full === expFull) else begin
			$display("error at %0t: full is %b for r%0d, expected %b", $time, full, idx, expFull);
			testErrors++;
		end
	endtask

	task automatic finishTest(input string name);
		runCycle(OP_NONE, 0, 0, 1'b0, 0);
		waited = 0;
		while ((expData.size() != 0) && (waited < 10)) begin
			@(posedge CLK);
			waited++;
		end
		if (expData.size() != 0) begin
			$display("timeout: %0d read results never came back in test %s", expData.size(), name);
			timedOut = 1'b1;
			testErrors++;
			expData.delete();
			expIdx.delete();
		end
		testsRun++;
		totalErrors += testErrors;
		if (testErrors == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, testErrors);
			testsFailed++;
		end
		testErrors = 0;
	endtask

	// read results are stable between edges, so they are compared at the falling edge.
	always @(negedge CLK) begin
		if (arstN && archReadDataValid) begin
			if (expData.size() == 0) begin
				$display("a read result arrived at %0t with no request outstanding", $time);
				testErrors++;
			end else begin
				gotExp = expData.pop_front();
				gotIdx = expIdx.pop_front();
				checks++;
				assert (archReadData === gotExp) else begin
					$display("error at %0t: read of r%0d gave %h, expected %h",
						$time, gotIdx, archReadData, gotExp);
					testErrors++;
				end
			end
		end
	end

	initial begin
		seed          = 41;
		checks        = 0;
		testErrors    = 0;
		totalErrors   = 0;
		testsRun      = 0;
		testsFailed   = 0;
		timedOut      = 1'b0;
		opKind        = OP_NONE;
		opIndex       = '0;
		opData        = '0;
		archReadValid = 1'b0;
		archReadIndex = '0;
		for (int r = 0; r < `RN_REGS; r++) committed[r] = '0;
		waited = 0;
		do begin
			@(posedge CLK);
			waited++;
		end while (!arstN && (waited < 20));
		if (!arstN) begin
			$display("timeout: reset was never released");
			timedOut = 1'b1;
		end

		for (int r = 0; r < `RN_REGS; r++) runCycle(OP_NONE, 0, 0, 1'b1, regIdx_t'(r));
		finishTest("reset values");

		runCycle(OP_WRITE, 5, 64'h1111_2222_3333_4444, 1'b1, 5);
		runCycle(OP_NONE, 0, 0, 1'b1, 5);  // uncommitted, still the old value.
		runCycle(OP_COMMIT, 5, 0, 1'b0, 0);
		runCycle(OP_WRITE, 5, 64'h5555_6666_7777_8888, 1'b1, 5);
		runCycle(OP_NONE, 0, 0, 1'b1, 5);
		finishTest("write and commit");

		for (int k = 0; k < 3; k++) runCycle(OP_WRITE, 7, 64'hA0 + k, 1'b1, 7);
		for (int k = 0; k < 3; k++) runCycle(OP_COMMIT, 7, 0, 1'b1, 7);
		runCycle(OP_NONE, 0, 0, 1'b1, 7);
		finishTest("commit order");

		// the fourth write finds the register full and must vanish.
		for (int k = 0; k < 4; k++) runCycle(OP_WRITE, 9, 64'hB0 + k, 1'b0, 0);
		for (int k = 0; k < 4; k++) runCycle(OP_COMMIT, 9, 0, 1'b1, 9);
		runCycle(OP_NONE, 9, 0, 1'b1, 9);
		finishTest("full and drop");

		runCycle(OP_WRITE, 3, 64'hC3, 1'b0, 0);
		runCycle(OP_WRITE, 4, 64'hC4, 1'b0, 0);
		runCycle(OP_FLUSH, 0, 0, 1'b1, 3);
		runCycle(OP_WRITE, 3, 64'hD3, 1'b1, 4);
		runCycle(OP_COMMIT, 3, 0, 1'b1, 3);
		runCycle(OP_COMMIT, 4, 0, 1'b1, 3);
		runCycle(OP_NONE, 0, 0, 1'b1, 4);
		finishTest("flush");

		// few registers so that full is reached, flushes kept rare.
		for (int n = 0; n < 500; n++) begin
			pick = $random(seed) & 15;
			if (pick < 7) kind = OP_WRITE;
			else if (pick < 13) kind = OP_COMMIT;
			else if (pick < 15) kind = OP_NONE;
			else kind = OP_FLUSH;
			runCycle(kind, regIdx_t'($random(seed) & 7), {$random(seed), $random(seed)},
				($random(seed) & 1) != 0, regIdx_t'($random(seed) & 7));
		end
		finishTest("random mix");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, totalErrors);
		if (timedOut || (totalErrors != 0)) begin
			$display("** FAIL **");
		end else begin
			$display("** PASS **");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+design
design/renamePkg.sv
design/rfWriteIf.sv
design/renameAlloc.sv
design/regFile.sv
design/commitTracker.sv
design/renameCore.sv
verif/clkGen.sv
verif/renameCore_checker.sv
verif/tb_renameCore.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_renameCore
FILELIST := tb.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
